//--- all.f
hdl/snn_shape_pkg.sv
hdl/snn_types_pkg.sv
hdl/spike_broadcast.sv
hdl/qkv_lane.sv
hdl/qkv_reshape.sv
hdl/spikformer_qkv_top.sv
test/qkv_properties.sv
test/spikformer_qkv_tb.sv

//--- hdl/qkv_lane.sv
// Projection lane with LIF neurons
`timescale 1ns/1ns
`default_nettype none

module qkv_lane #(
    parameter int LANE_ID = 0
) (
    input  logic                                      s_clk,
    input  logic                                      i_rst,

    input  logic                                      i_valid,
    input  logic [snn_shape_pkg::D_IN-1:0]            i_spikes,
    input  logic [snn_shape_pkg::STEP_W-1:0]          i_step,
    output logic                                      o_ready,

    input  logic signed [snn_shape_pkg::PSUM_W-1:0]   i_lif_thrd,

    input  logic                                      i_wt_we,
    input  logic [1:0]                                i_wt_lane,
    input  logic [1:0]                                i_wt_row,
    input  logic [2:0]                                i_wt_col,
    input  logic signed [snn_shape_pkg::WEIGHT_W-1:0] i_wt_data,

    input  logic                                      i_out_ready,
    output logic                                      o_valid,
    output logic [snn_shape_pkg::D_OUT-1:0]           o_spikes,
    output logic [snn_shape_pkg::STEP_W-1:0]          o_step
);

    localparam int D_IN     = snn_shape_pkg::D_IN;
    localparam int D_OUT    = snn_shape_pkg::D_OUT;
    localparam int WEIGHT_W = snn_shape_pkg::WEIGHT_W;
    localparam int PSUM_W   = snn_shape_pkg::PSUM_W;
    localparam int PAD_W    = PSUM_W - WEIGHT_W;

    logic signed [WEIGHT_W-1:0] weight  [D_OUT][D_IN];
    logic signed [PSUM_W-1:0]   v_mem   [D_OUT];        // Membrane potential per channel
    logic signed [PSUM_W-1:0]   psum    [D_OUT];
    logic signed [PSUM_W-1:0]   mem_sum [D_OUT];
    logic [D_OUT-1:0]           fire;
    logic                       wt_hit;
    logic                       take;

    assign wt_hit  = i_wt_we && (i_wt_lane == 2'(LANE_ID));
    assign o_ready = !o_valid || i_out_ready;
    assign take    = i_valid && o_ready;

    // Binary inputs select which weights of a row add up
    always_comb begin
        for (int r = 0; r < D_OUT; r++) begin
            psum[r] = '0;
            for (int c = 0; c < D_IN; c++) begin
                if (i_spikes[c]) begin
                    psum[r] = psum[r] + {{PAD_W{weight[r][c][WEIGHT_W-1]}}, weight[r][c]};
                end
            end
            mem_sum[r] = (i_step == '0) ? psum[r] : v_mem[r] + psum[r]; // Fresh start at step 0
            fire[r]    = (mem_sum[r] >= i_lif_thrd);
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_rst) begin
            for (int r = 0; r < D_OUT; r++) begin
                v_mem[r] <= '0;
                for (int c = 0; c < D_IN; c++) begin
                    weight[r][c] <= '0;
                end
            end
            o_valid  <= 1'b0;
            o_spikes <= '0;
            o_step   <= '0;
        end else begin
            if (wt_hit) begin
                weight[i_wt_row][i_wt_col] <= i_wt_data;
            end
            if (take) begin
                for (int r = 0; r < D_OUT; r++) begin
                    v_mem[r] <= fire[r] ? '0 : mem_sum[r];  // Hard reset on spike
                end
                o_spikes <= fire;
                o_step   <= i_step;
                o_valid  <= 1'b1;
            end else if (i_out_ready) begin
                o_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/qkv_reshape.sv
// QKV token line reshape
`timescale 1ns/1ns
`default_nettype none

module qkv_reshape (
    input  logic                                                   s_clk,
    input  logic                                                   i_rst,

    input  logic [snn_shape_pkg::NUM_LANES-1:0]                    i_spk_valid,
    input  logic [snn_shape_pkg::NUM_LANES*snn_shape_pkg::D_OUT-1:0]  i_spk_vector,
    input  logic [snn_shape_pkg::NUM_LANES*snn_shape_pkg::STEP_W-1:0] i_spk_step,
    output logic [snn_shape_pkg::NUM_LANES-1:0]                    o_spk_ready,

    input  logic                                                   i_line_ready,
    output logic                                                   o_line_valid,
    output logic [snn_shape_pkg::LINE_W-1:0]                       o_q_line,
    output logic [snn_shape_pkg::LINE_W-1:0]                       o_k_line,
    output logic [snn_shape_pkg::LINE_W-1:0]                       o_v_line
);

    localparam int NUM_LANES  = snn_shape_pkg::NUM_LANES;
    localparam int TIME_STEPS = snn_shape_pkg::TIME_STEPS;
    localparam int D_OUT      = snn_shape_pkg::D_OUT;
    localparam int STEP_W     = snn_shape_pkg::STEP_W;

    snn_types_pkg::spike_line_u coll_line [NUM_LANES];  // Token being collected
    snn_types_pkg::spike_line_u out_line  [NUM_LANES];  // Token on offer
    logic [TIME_STEPS-1:0]      fill      [NUM_LANES];
    logic [STEP_W-1:0]          lane_step [NUM_LANES];
    logic [NUM_LANES-1:0]       take;
    logic                       all_full;
    logic                       move;

    // Collection complete and output free or draining this cycle
    always_comb begin
        all_full = 1'b1;
        for (int l = 0; l < NUM_LANES; l++) begin
            all_full = all_full && (&fill[l]);
        end
        move = all_full && (!o_line_valid || i_line_ready);
    end

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            lane_step[l]   = i_spk_step[l*STEP_W +: STEP_W];
            o_spk_ready[l] = !fill[l][lane_step[l]] || move;   // Slot frees as the line moves
            take[l]        = i_spk_valid[l] && o_spk_ready[l];
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_rst) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                fill[l] <= '0;
            end
            o_line_valid <= 1'b0;
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (move) begin
                    fill[l] <= '0;
                end
                if (take[l]) begin
                    fill[l][lane_step[l]] <= 1'b1;
                end
            end
            if (move) begin
                o_line_valid <= 1'b1;
            end else if (i_line_ready) begin
                o_line_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_clk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (take[l]) begin
                coll_line[l].by_step[lane_step[l]] <= i_spk_vector[l*D_OUT +: D_OUT];
            end
            if (move) begin
                out_line[l] <= coll_line[l];
            end
        end
    end

    assign o_q_line = out_line[snn_types_pkg::LANE_Q].flat;
    assign o_k_line = out_line[snn_types_pkg::LANE_K].flat;
    assign o_v_line = out_line[snn_types_pkg::LANE_V].flat;

endmodule

`default_nettype wire

//--- hdl/snn_shape_pkg.sv
// Network slice dimensions
`default_nettype none

package snn_shape_pkg;

    localparam int TIME_STEPS = 4;                  // Spike vectors per token
    localparam int D_IN       = 8;                  // Input features
    localparam int D_OUT      = 4;                  // Output channels per lane
    localparam int NUM_LANES  = 3;                  // Q, K and V

    localparam int WEIGHT_W   = 8;                  // Signed weight
    localparam int PSUM_W     = 20;                 // Psum and membrane potential, signed

    localparam int STEP_W     = $clog2(TIME_STEPS);

    // One token line holds every step of one lane
    localparam int LINE_W     = TIME_STEPS * D_OUT;

endpackage

`default_nettype wire

//--- hdl/snn_types_pkg.sv
// Lane ids and spike line type
`default_nettype none

package snn_types_pkg;

    localparam int LANE_Q = 0;
    localparam int LANE_K = 1;
    localparam int LANE_V = 2;

    // Token line of one lane
    // by_step is written slot by slot in the drain, flat leaves the top
    typedef union packed {
        logic [snn_shape_pkg::TIME_STEPS-1:0][snn_shape_pkg::D_OUT-1:0] by_step;
        logic [snn_shape_pkg::LINE_W-1:0]                               flat;
    } spike_line_u;

endpackage

`default_nettype wire

//--- hdl/spike_broadcast.sv
// Input spike feeder
`timescale 1ns/1ns
`default_nettype none

module spike_broadcast (
    input  logic                                 s_clk,
    input  logic                                 i_rst,

    input  logic                                 i_x_valid,
    input  logic [snn_shape_pkg::D_IN-1:0]       i_x_spikes,
    output logic                                 o_x_ready,

    input  logic [snn_shape_pkg::NUM_LANES-1:0]  i_lane_ready,
    output logic                                 o_bcast_valid,
    output logic [snn_shape_pkg::D_IN-1:0]       o_bcast_spikes,
    output logic [snn_shape_pkg::STEP_W-1:0]     o_bcast_step
);

    localparam logic [snn_shape_pkg::STEP_W-1:0] LAST_STEP =
        snn_shape_pkg::STEP_W'(snn_shape_pkg::TIME_STEPS - 1);

    logic [snn_shape_pkg::STEP_W-1:0] step_cnt;

    // A beat moves only when every lane can take it
    assign o_x_ready      = &i_lane_ready;
    assign o_bcast_valid  = i_x_valid && o_x_ready;
    assign o_bcast_spikes = i_x_spikes;
    assign o_bcast_step   = step_cnt;

    // Step position inside the current token
    always_ff @(posedge s_clk) begin
        if (i_rst) begin
            step_cnt <= '0;
        end else if (o_bcast_valid) begin
            if (step_cnt == LAST_STEP) begin
                step_cnt <= '0;                     // Token done
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/spikformer_qkv_top.sv
// Spikformer QKV projection top
`timescale 1ns/1ns
`default_nettype none

module spikformer_qkv_top (
    input  logic                                      s_clk,
    input  logic                                      i_rst,

    input  logic                                      i_x_valid,
    input  logic [snn_shape_pkg::D_IN-1:0]            i_x_spikes,
    output logic                                      o_x_ready,

    input  logic                                      i_wt_we,
    input  logic [1:0]                                i_wt_lane,
    input  logic [1:0]                                i_wt_row,
    input  logic [2:0]                                i_wt_col,
    input  logic signed [snn_shape_pkg::WEIGHT_W-1:0] i_wt_data,

    input  logic signed [snn_shape_pkg::PSUM_W-1:0]   i_lif_thrd,

    input  logic                                      i_line_ready,
    output logic                                      o_line_valid,
    output logic [snn_shape_pkg::LINE_W-1:0]          o_q_line,
    output logic [snn_shape_pkg::LINE_W-1:0]          o_k_line,
    output logic [snn_shape_pkg::LINE_W-1:0]          o_v_line
);

    logic                                                      bcast_valid;
    logic [snn_shape_pkg::D_IN-1:0]                            bcast_spikes;
    logic [snn_shape_pkg::STEP_W-1:0]                          bcast_step;
    logic [snn_shape_pkg::NUM_LANES-1:0]                       lane_ready;

    logic [snn_shape_pkg::NUM_LANES-1:0]                       spk_valid;
    logic [snn_shape_pkg::NUM_LANES*snn_shape_pkg::D_OUT-1:0]  spk_vector;
    logic [snn_shape_pkg::NUM_LANES*snn_shape_pkg::STEP_W-1:0] spk_step;
    logic [snn_shape_pkg::NUM_LANES-1:0]                       spk_ready;

    spike_broadcast u_feeder (
        .s_clk          (s_clk),
        .i_rst          (i_rst),
        .i_x_valid      (i_x_valid),
        .i_x_spikes     (i_x_spikes),
        .o_x_ready      (o_x_ready),
        .i_lane_ready   (lane_ready),
        .o_bcast_valid  (bcast_valid),
        .o_bcast_spikes (bcast_spikes),
        .o_bcast_step   (bcast_step)
    );

    // Lane g computes projection g, Q then K then V
    for (genvar g = 0; g < snn_shape_pkg::NUM_LANES; g++) begin : g_lane
        qkv_lane #(
            .LANE_ID (g)
        ) u_lane (
            .s_clk       (s_clk),
            .i_rst       (i_rst),
            .i_valid     (bcast_valid),
            .i_spikes    (bcast_spikes),
            .i_step      (bcast_step),
            .o_ready     (lane_ready[g]),
            .i_lif_thrd  (i_lif_thrd),
            .i_wt_we     (i_wt_we),
            .i_wt_lane   (i_wt_lane),
            .i_wt_row    (i_wt_row),
            .i_wt_col    (i_wt_col),
            .i_wt_data   (i_wt_data),
            .i_out_ready (spk_ready[g]),
            .o_valid     (spk_valid[g]),
            .o_spikes    (spk_vector[g*snn_shape_pkg::D_OUT +: snn_shape_pkg::D_OUT]),
            .o_step      (spk_step[g*snn_shape_pkg::STEP_W +: snn_shape_pkg::STEP_W])
        );
    end

    qkv_reshape u_drain (
        .s_clk        (s_clk),
        .i_rst        (i_rst),
        .i_spk_valid  (spk_valid),
        .i_spk_vector (spk_vector),
        .i_spk_step   (spk_step),
        .o_spk_ready  (spk_ready),
        .i_line_ready (i_line_ready),
        .o_line_valid (o_line_valid),
        .o_q_line     (o_q_line),
        .o_k_line     (o_k_line),
        .o_v_line     (o_v_line)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 -f all.f --top-module spikformer_qkv_tb -o simv

out=$(./obj_dir/simv)
printf '%s\n' "$out"

# The run counts as passed only when the testbench printed its pass line
printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"

//--- test/qkv_properties.sv
// QKV top protocol checks
`timescale 1ns/1ns
`default_nettype none

module qkv_properties (
    input logic                             s_clk,
    input logic                             i_rst,
    input logic                             o_x_ready,
    input logic                             i_line_ready,
    input logic                             o_line_valid,
    input logic [snn_shape_pkg::LINE_W-1:0] o_q_line,
    input logic [snn_shape_pkg::LINE_W-1:0] o_k_line,
    input logic [snn_shape_pkg::LINE_W-1:0] o_v_line
);

    // Offered line holds until it is taken
    a_line_hold: assert property (@(posedge s_clk) disable iff (i_rst)
        (o_line_valid && !i_line_ready) |=> (o_line_valid && $stable(o_q_line)
            && $stable(o_k_line) && $stable(o_v_line)))
        else $error("Line valid or line data changed while the output was stalled");

    a_valid_reset: assert property (@(posedge s_clk) i_rst |=> !o_line_valid)
        else $error("Line valid high during reset or in the first cycle after it");

    a_ready_after_reset: assert property (@(posedge s_clk) $fell(i_rst) |-> o_x_ready)
        else $error("Input not ready in the first cycle after reset");

endmodule

`default_nettype wire

//--- test/spikformer_qkv_tb.sv
// QKV projection testbench
`timescale 1ns/1ns
`default_nettype none

module spikformer_qkv_tb;

    localparam int TIME_STEPS = snn_shape_pkg::TIME_STEPS;
    localparam int D_IN       = snn_shape_pkg::D_IN;
    localparam int D_OUT      = snn_shape_pkg::D_OUT;
    localparam int NUM_LANES  = snn_shape_pkg::NUM_LANES;
    localparam int LINE_W     = snn_shape_pkg::LINE_W;
    localparam int PSUM_W     = snn_shape_pkg::PSUM_W;
    localparam int NUM_TOKENS = 12;                     // Tokens sent over all tests

    logic                    s_clk;
    logic                    i_rst;
    logic                    i_x_valid;
    logic [D_IN-1:0]         i_x_spikes;
    logic                    o_x_ready;
    logic                    i_wt_we;
    logic [1:0]              i_wt_lane;
    logic [1:0]              i_wt_row;
    logic [2:0]              i_wt_col;
    logic signed [7:0]       i_wt_data;
    logic signed [PSUM_W-1:0] i_lif_thrd;
    logic                    i_line_ready;
    logic                    o_line_valid;
    logic [LINE_W-1:0]       o_q_line;
    logic [LINE_W-1:0]       o_k_line;
    logic [LINE_W-1:0]       o_v_line;

    logic signed [7:0]       wt_model [NUM_LANES][D_OUT][D_IN] = '{default: '0};
    logic [NUM_LANES*LINE_W-1:0] exp_q [$];            // Expected lines, Q in the low bits
    logic [NUM_LANES*LINE_W-1:0] exp_lines;
    logic [TIME_STEPS*D_IN-1:0]  tok;
    logic [31:0]             rng = 32'hb77e;
    int                      thrd;
    int                      errors;
    int                      checks;
    int                      tests;
    int                      test_errors;
    string                   test_name;

    spikformer_qkv_top UUT (.*);

    bind spikformer_qkv_top qkv_properties u_props (
        .s_clk        (s_clk),
        .i_rst        (i_rst),
        .o_x_ready    (o_x_ready),
        .i_line_ready (i_line_ready),
        .o_line_valid (o_line_valid),
        .o_q_line     (o_q_line),
        .o_k_line     (o_k_line),
        .o_v_line     (o_v_line)
    );

    initial begin
        s_clk = 1'b0;
        forever #5 s_clk = ~s_clk;
    end

    initial begin
        #(NUM_TOKENS * 200 * 10);
        $display("Timeout after %0d cycles, the DUT stopped moving data", NUM_TOKENS * 200);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    // LIF model per lane and channel, membrane starts at zero for each token
    task automatic predict_lines(input logic [TIME_STEPS*D_IN-1:0] x);
        logic [NUM_LANES*LINE_W-1:0] lines;
        int v;
        int psum;
        lines = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int r = 0; r < D_OUT; r++) begin
                v = 0;
                for (int s = 0; s < TIME_STEPS; s++) begin
                    psum = 0;
                    for (int c = 0; c < D_IN; c++) begin
                        if (x[s*D_IN + c]) psum += int'(wt_model[l][r][c]);
                    end
                    v = v + psum;
                    if (v >= thrd) begin
                        lines[l*LINE_W + s*D_OUT + r] = 1'b1;
                        v = 0;
                    end
                end
            end
        end
        exp_q.push_back(lines);
    endtask

    task automatic write_weight(input int lane, input int row, input int col,
                                input logic [7:0] data);
        i_wt_we   = 1'b1;
        i_wt_lane = lane[1:0];
        i_wt_row  = row[1:0];
        i_wt_col  = col[2:0];
        i_wt_data = data;
        wt_model[lane][row][col] = data;
        @(posedge s_clk);
        #1;
        i_wt_we = 1'b0;
    endtask

    // Random fill, or 20 in column 0 of every row
    task automatic load_weights(input bit random_fill);
        logic [31:0] rnd;
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int r = 0; r < D_OUT; r++) begin
                for (int c = 0; c < D_IN; c++) begin
                    rnd = xorshift();
                    write_weight(l, r, c, random_fill ? rnd[7:0] : ((c == 0) ? 8'd20 : 8'd0));
                end
            end
        end
    endtask

    task automatic set_threshold(input int t);
        thrd       = t;
        i_lif_thrd = t[PSUM_W-1:0];
    endtask

    task automatic send_beat(input logic [D_IN-1:0] spikes);
        i_x_valid  = 1'b1;
        i_x_spikes = spikes;
        @(negedge s_clk);
        while (!o_x_ready) @(negedge s_clk);
        @(posedge s_clk);
        #1;
        i_x_valid = 1'b0;
    endtask

    task automatic send_token(input logic [TIME_STEPS*D_IN-1:0] x);
        predict_lines(x);
        for (int s = 0; s < TIME_STEPS; s++) begin
            send_beat(x[s*D_IN +: D_IN]);
        end
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) @(posedge s_clk);
        #1;
    endtask

    task automatic check_true(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("%s in test %s", msg, test_name);
            errors++;
        end
    endtask

    task automatic end_test();
        tests++;
        $display("Test %s %s", test_name, (errors == test_errors) ? "passed" : "failed");
        test_errors = errors;
    endtask

    // Lines are taken on the next rising edge, so compare at the falling one
    always @(negedge s_clk) begin
        if (!i_rst && o_line_valid && i_line_ready) begin
            checks++;
            if (exp_q.size() == 0) begin
                $display("Line appeared with no token outstanding in test %s", test_name);
                errors++;
            end else begin
                exp_lines = exp_q.pop_front();
                assert ({o_v_line, o_k_line, o_q_line} == exp_lines) else begin
                    $display("Mismatch in %s: expected v,k,q %h, actual %h", test_name,
                             exp_lines, {o_v_line, o_k_line, o_q_line});
                    errors++;
                end
            end
        end
    end

    initial begin
        i_rst        = 1'b1;
        i_x_valid    = 1'b0;
        i_x_spikes   = '0;
        i_wt_we      = 1'b0;
        i_wt_lane    = '0;
        i_wt_row     = '0;
        i_wt_col     = '0;
        i_wt_data    = '0;
        i_line_ready = 1'b1;
        set_threshold(5);
        repeat (4) @(posedge s_clk);
        #1;
        i_rst = 1'b0;

        test_name = "reset_state";
        check_true(!o_line_valid && o_x_ready, "Line valid high or input not ready after reset");
        send_token(xorshift());
        wait_drained();
        end_test();

        test_name = "lane_weights";
        set_threshold(60);
        load_weights(1'b1);
        repeat (4) send_token(xorshift());
        wait_drained();
        end_test();

        test_name = "threshold";
        set_threshold(40);                              // Twice the row sum of 20
        load_weights(1'b0);
        send_token('1);
        wait_drained();
        end_test();

        test_name = "membrane_restart";
        send_token(32'h00ff_ffff);                      // Leaves 20 in every membrane
        send_token('1);
        wait_drained();
        end_test();

        test_name = "back_pressure";
        set_threshold(60);
        load_weights(1'b1);
        i_line_ready = 1'b0;
        fork
            begin
                repeat (20) @(posedge s_clk);
                #1;
                i_line_ready = 1'b1;
            end
            repeat (3) send_token(xorshift());
        join
        wait_drained();
        end_test();

        test_name = "latency";
        tok = xorshift();
        send_token(tok);
        @(posedge s_clk);
        #1;
        check_true(!o_line_valid, "Line valid rose one cycle after the last beat");
        @(posedge s_clk);
        #1;
        check_true(o_line_valid, "Line valid still low two cycles after the last beat");
        wait_drained();
        end_test();

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
